// ==== logic/miner_pkg.sv ====
// SHA3-256 miner shared definitions
// Widths, bus register map, control and status bit positions,
// and the compressed Keccak round constants
package miner_pkg;

   localparam int SPONGE_W = 1600;
   localparam int LANE_W   = 64;
   localparam int HASH_W   = 256;
   localparam int NONCE_W  = 64;
   localparam int DATA_W   = 32;
   localparam int ADDR_W   = 7;
   localparam int ROUNDS   = 24;

   typedef logic [SPONGE_W-1:0] sponge_t;
   typedef logic [HASH_W-1:0]   hash_t;
   typedef logic [NONCE_W-1:0]  nonce_t;

   // Control word bits
   typedef enum int {
      CTL_RUN  = 0,
      CTL_TEST = 1,
      CTL_HALT = 2
   } ctl_bit_e;

   // Low bit of the padding byte fields in the control word
   localparam int PADL_LSB = 16;
   localparam int PADF_LSB = 24;

   // Bus word indices, byte address divided by 4
   typedef enum logic [4:0] {
      REG_SOLN_LO = 5'd0,
      REG_SOLN_HI = 5'd1,
      REG_STATUS  = 5'd2,
      REG_ID      = 5'd3,
      REG_HDR     = 5'd4,
      REG_DIFF    = 5'd12,
      REG_START   = 5'd20,
      REG_CTL     = 5'd22
   } reg_idx_e;

   localparam logic [DATA_W-1:0] ID_WORD = "SHA3";

   // Status word bits
   localparam int ST_FOUND   = 0;
   localparam int ST_RUNNING = 1;
   localparam int ST_TESTING = 2;

   // Round constants, bit k maps to lane bit 2**k - 1
   localparam logic [6:0] RC_TABLE [0:ROUNDS-1] = '{
      7'h01, 7'h1a, 7'h5e, 7'h70, 7'h1f, 7'h21, 7'h79, 7'h55,
      7'h0e, 7'h0c, 7'h35, 7'h26, 7'h3f, 7'h4f, 7'h5d, 7'h53,
      7'h52, 7'h48, 7'h16, 7'h66, 7'h79, 7'h58, 7'h21, 7'h74
   };

endpackage

// ==== logic/keccak_round.sv ====
// Registered Keccak-f[1600] round
// Theta, rho, pi, chi and iota on the full state in one cycle,
// with the round constant given in compressed 7-bit form
`timescale 1ns/1ns

module keccak_round (
   input  logic                clk,
   input  miner_pkg::sponge_t  state_i,
   input  logic [6:0]          rc_i,
   output miner_pkg::sponge_t  state_o
);

   localparam int LW = miner_pkg::LANE_W;

   // Rho rotation per lane, indexed by 5*y + x
   localparam int RHO [0:24] = '{
       0,  1, 62, 28, 27,
      36, 44,  6, 55, 20,
       3, 10, 43, 25, 39,
      41, 45, 15, 21,  8,
      18,  2, 61, 56, 14
   };

   logic [LW-1:0]       a   [25];
   logic [LW-1:0]       col [5];
   logic [LW-1:0]       d   [5];
   logic [LW-1:0]       b   [25];
   logic [LW-1:0]       f   [25];
   miner_pkg::sponge_t  next_state;

   function automatic logic [LW-1:0] rotl(input logic [LW-1:0] v, input int n);
      return (n == 0) ? v : ((v << n) | (v >> (LW - n)));
   endfunction

   function automatic logic [LW-1:0] rc_expand(input logic [6:0] rc);
      logic [LW-1:0] v;
      v = '0;
      for (int k = 0; k < 7; k++) begin
         v[(1 << k) - 1] = rc[k];
      end
      return v;
   endfunction

   // Lane 0 sits in the most significant 64 bits
   always_comb begin
      for (int i = 0; i < 25; i++) begin
         a[i] = state_i[miner_pkg::SPONGE_W-1-LW*i -: LW];
      end
   end

   // Theta
   always_comb begin
      for (int x = 0; x < 5; x++) begin
         col[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
      end
      for (int x = 0; x < 5; x++) begin
         d[x] = col[(x+4)%5] ^ rotl(col[(x+1)%5], 1);
      end
   end

   // Rho and pi, lane (x,y) moves to (y, 2x+3y)
   always_comb begin
      for (int y = 0; y < 5; y++) begin
         for (int x = 0; x < 5; x++) begin
            b[5*((2*x+3*y)%5) + y] = rotl(a[5*y+x] ^ d[x], RHO[5*y+x]);
         end
      end
   end

   // Chi, then iota on lane 0
   always_comb begin
      for (int y = 0; y < 5; y++) begin
         for (int x = 0; x < 5; x++) begin
            f[5*y+x] = b[5*y+x] ^ (~b[5*y+(x+1)%5] & b[5*y+(x+2)%5]);
         end
      end
      f[0] = f[0] ^ rc_expand(rc_i);
   end

   always_comb begin
      for (int i = 0; i < 25; i++) begin
         next_state[miner_pkg::SPONGE_W-1-LW*i -: LW] = f[i];
      end
   end

   always_ff @(posedge clk) begin
      state_o <= next_state;
   end

endmodule

// ==== logic/keccak_pipeline.sv ====
// Keccak round ring
// Builds the absorb block from header, nonce and padding, cycles it
// through STAGES round stages and extracts the 256-bit hash
`timescale 1ns/1ns

module keccak_pipeline #(
   parameter int STAGES = 4
) (
   input  logic               clk,
   input  miner_pkg::hash_t   header_i,
   input  miner_pkg::nonce_t  nonce_i,
   input  logic [7:0]         padf_i,
   input  logic [7:0]         padl_i,
   input  logic               pass_zero_i,
   input  logic [4:0]         cycle_i,
   output miner_pkg::hash_t   hash_o
);

   localparam int LW = miner_pkg::LANE_W;

   logic [5*LW-1:0]     msg_le;
   logic [5*LW-1:0]     msg_be;
   logic [767:0]        pad;
   miner_pkg::sponge_t  absorb_block;
   miner_pkg::hash_t    hash_be;
   miner_pkg::sponge_t  stage_state [STAGES];

   function automatic logic [LW-1:0] bswap64(input logic [LW-1:0] v);
      logic [LW-1:0] r;
      for (int b = 0; b < 8; b++) begin
         r[8*b +: 8] = v[8*(7-b) +: 8];
      end
      return r;
   endfunction

   // Round constant for a stage, from the cycle its block entered the stage
   function automatic logic [6:0] stage_rc(input logic [4:0] cyc, input int stage);
      int t;
      int idx;
      t = (int'(cyc) >= stage) ? int'(cyc) - stage : int'(cyc) + miner_pkg::ROUNDS - stage;
      idx = (t / STAGES) * STAGES + stage;
      return (idx < miner_pkg::ROUNDS) ? miner_pkg::RC_TABLE[idx] : 7'd0;
   endfunction

   assign msg_le = {header_i, nonce_i};

   always_comb begin
      for (int w = 0; w < 5; w++) begin
         msg_be[LW*w +: LW] = bswap64(msg_le[LW*w +: LW]);
      end
   end

   assign pad          = {56'b0, padf_i, 640'b0, padl_i, 56'b0};
   assign absorb_block = {msg_be, pad, 512'b0};

   for (genvar i = 0; i < STAGES; i++) begin : g_stage
      miner_pkg::sponge_t  stage_in;
      logic [6:0]          rc;

      if (i == 0) begin : g_head
         // Fresh block in pass zero, otherwise recirculate
         assign stage_in = pass_zero_i ? absorb_block : stage_state[STAGES-1];
      end else begin : g_body
         assign stage_in = stage_state[i-1];
      end

      assign rc = stage_rc(cycle_i, i);

      keccak_round u_round (
         .clk     (clk),
         .state_i (stage_in),
         .rc_i    (rc),
         .state_o (stage_state[i])
      );
   end

   assign hash_be = stage_state[STAGES-1][miner_pkg::SPONGE_W-1 -: miner_pkg::HASH_W];

   always_comb begin
      for (int w = 0; w < 4; w++) begin
         hash_o[LW*w +: LW] = bswap64(hash_be[LW*w +: LW]);
      end
   end

endmodule

// ==== logic/nonce_search.sv ====
// Nonce search sequencer
// Runs the mod-24 cycle counter, skips the first period of invalid
// hashes, steps the nonce and latches the first matching solution
`timescale 1ns/1ns

module nonce_search #(
   parameter int STAGES = 4
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               run_i,
   input  logic               test_i,
   input  logic               halt_i,
   input  miner_pkg::nonce_t  start_nonce_i,
   input  miner_pkg::hash_t   difficulty_i,
   input  miner_pkg::hash_t   hash_i,
   output miner_pkg::nonce_t  nonce_o,
   output logic               pass_zero_o,
   output logic [4:0]         cycle_o,
   output miner_pkg::nonce_t  solution_o,
   output logic [2:0]         status_o
);

   localparam logic [4:0] LAST_CYCLE = 5'(miner_pkg::ROUNDS - 1);
   // Idle value, the first running cycle wraps it to 0
   localparam logic [4:0] IDLE_CYCLE = 5'd31;

   logic [4:0]         cycle_q;
   logic [4:0]         skip_q;
   logic               found_q;
   miner_pkg::nonce_t  nonce_q;
   logic               pass_zero;
   logic               hash_valid;
   logic               match;

   assign pass_zero  = cycle_q < 5'(STAGES);
   assign hash_valid = skip_q == '0;

   // Hashes leave the ring only during pass zero
   assign match = (test_i ? (hash_i == difficulty_i) : (hash_i <= difficulty_i))
                  && hash_valid && pass_zero;

   always_ff @(posedge clk) begin
      if (reset || !run_i) begin
         found_q <= 1'b0;
         skip_q  <= 5'(miner_pkg::ROUNDS);
         cycle_q <= IDLE_CYCLE;
         nonce_q <= start_nonce_i;
      end else if (!found_q) begin
         skip_q  <= hash_valid ? 5'd0 : skip_q - 5'd1;
         cycle_q <= (cycle_q == LAST_CYCLE) ? 5'd0 : cycle_q + 5'd1;
         if ((match || halt_i) && hash_valid) begin
            // Hash at the output belongs to the nonce STAGES steps back
            nonce_q <= nonce_q - miner_pkg::NONCE_W'(STAGES);
            found_q <= 1'b1;
         end else if (pass_zero) begin
            nonce_q <= nonce_q + 1'b1;
         end
      end
   end

   assign nonce_o     = nonce_q;
   assign solution_o  = nonce_q;
   assign pass_zero_o = pass_zero;
   assign cycle_o     = cycle_q;

   assign status_o[miner_pkg::ST_FOUND]   = found_q & ~halt_i;
   assign status_o[miner_pkg::ST_RUNNING] = run_i;
   assign status_o[miner_pkg::ST_TESTING] = test_i;

endmodule

// ==== logic/miner_regs.sv ====
// SHA3 miner bus register file
// Holds header, difficulty, start nonce and control words written
// over a Wishbone-style bus and returns solution, status and ID
`timescale 1ns/1ns

module miner_regs (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          wb_cyc_i,
   input  logic                          wb_stb_i,
   input  logic                          wb_we_i,
   input  logic [3:0]                    wb_sel_i,
   input  logic [miner_pkg::ADDR_W-1:0]  wb_adr_i,
   input  logic [miner_pkg::DATA_W-1:0]  wb_dat_i,
   input  miner_pkg::nonce_t             solution_i,
   input  logic [2:0]                    status_i,
   output logic                          wb_ack_o,
   output logic [miner_pkg::DATA_W-1:0]  wb_dat_o,
   output miner_pkg::hash_t              header_o,
   output miner_pkg::hash_t              difficulty_o,
   output miner_pkg::nonce_t             start_nonce_o,
   output logic                          run_o,
   output logic                          test_o,
   output logic                          halt_o,
   output logic [7:0]                    padf_o,
   output logic [7:0]                    padl_o
);

   localparam int HDR   = miner_pkg::REG_HDR;
   localparam int DIFF  = miner_pkg::REG_DIFF;
   localparam int START = miner_pkg::REG_START;
   localparam int CTL   = miner_pkg::REG_CTL;

   logic [miner_pkg::DATA_W-1:0] job_q [HDR:CTL-1];
   logic [miner_pkg::DATA_W-1:0] ctl_q;
   logic [miner_pkg::DATA_W-1:0] rd_data;
   logic [4:0]                   idx;
   logic                         bus_req;
   logic                         wr_en;
   logic                         ack_q;

   assign idx      = wb_adr_i[miner_pkg::ADDR_W-1:2];
   assign bus_req  = wb_cyc_i & wb_stb_i;
   // Only the first edge of a strobe writes
   assign wr_en    = bus_req & wb_we_i & ~ack_q;
   assign wb_ack_o = ack_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         ack_q <= 1'b0;
         ctl_q <= '0;
      end else begin
         ack_q <= bus_req & ~ack_q;
         if (wr_en && idx == miner_pkg::REG_CTL) begin
            for (int b = 0; b < 4; b++) begin
               if (wb_sel_i[b]) begin
                  ctl_q[8*b +: 8] <= wb_dat_i[8*b +: 8];
               end
            end
         end
      end
   end

   // Job words, byte lanes follow the select bits
   always_ff @(posedge clk) begin
      for (int w = HDR; w < CTL; w++) begin
         for (int b = 0; b < 4; b++) begin
            if (wr_en && idx == w && wb_sel_i[b]) begin
               job_q[w][8*b +: 8] <= wb_dat_i[8*b +: 8];
            end
         end
      end
   end

   always_comb begin
      rd_data = '0;
      for (int w = HDR; w < CTL; w++) begin
         if (idx == w) begin
            rd_data = job_q[w];
         end
      end
      case (idx)
         miner_pkg::REG_SOLN_LO: rd_data = solution_i[31:0];
         miner_pkg::REG_SOLN_HI: rd_data = solution_i[63:32];
         miner_pkg::REG_STATUS:  rd_data = {{(miner_pkg::DATA_W-3){1'b0}}, status_i};
         miner_pkg::REG_ID:      rd_data = miner_pkg::ID_WORD;
         miner_pkg::REG_CTL:     rd_data = ctl_q;
         default: ;
      endcase
   end

   // Read data is presented with the ack pulse
   always_ff @(posedge clk) begin
      if (bus_req && !ack_q) begin
         wb_dat_o <= rd_data;
      end
   end

   // Lowest word index lands in the most significant position
   always_comb begin
      for (int k = 0; k < 8; k++) begin
         header_o[miner_pkg::HASH_W-1-32*k -: 32]     = job_q[HDR+k];
         difficulty_o[miner_pkg::HASH_W-1-32*k -: 32] = job_q[DIFF+k];
      end
   end

   assign start_nonce_o = {job_q[START], job_q[START+1]};

   assign run_o  = ctl_q[miner_pkg::CTL_RUN];
   assign test_o = ctl_q[miner_pkg::CTL_TEST];
   assign halt_o = ctl_q[miner_pkg::CTL_HALT];
   assign padf_o = ctl_q[miner_pkg::PADF_LSB +: 8];
   assign padl_o = ctl_q[miner_pkg::PADL_LSB +: 8];

endmodule

// ==== logic/miner_top.sv ====
// SHA3-256 proof-of-work miner
// Bus register file, nonce search control and Keccak round ring
`timescale 1ns/1ns

module miner_top #(
   parameter int STAGES = 4
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          wb_cyc_i,
   input  logic                          wb_stb_i,
   input  logic                          wb_we_i,
   input  logic [3:0]                    wb_sel_i,
   input  logic [miner_pkg::ADDR_W-1:0]  wb_adr_i,
   input  logic [miner_pkg::DATA_W-1:0]  wb_dat_i,
   output logic                          wb_ack_o,
   output logic [miner_pkg::DATA_W-1:0]  wb_dat_o
);

   miner_pkg::hash_t   header;
   miner_pkg::hash_t   difficulty;
   miner_pkg::hash_t   hash;
   miner_pkg::nonce_t  start_nonce;
   miner_pkg::nonce_t  nonce;
   miner_pkg::nonce_t  solution;
   logic               run;
   logic               test;
   logic               halt;
   logic [7:0]         padf;
   logic [7:0]         padl;
   logic               pass_zero;
   logic [4:0]         cycle;
   logic [2:0]         status;

   miner_regs u_regs (
      .clk           (clk),
      .reset         (reset),
      .wb_cyc_i      (wb_cyc_i),
      .wb_stb_i      (wb_stb_i),
      .wb_we_i       (wb_we_i),
      .wb_sel_i      (wb_sel_i),
      .wb_adr_i      (wb_adr_i),
      .wb_dat_i      (wb_dat_i),
      .solution_i    (solution),
      .status_i      (status),
      .wb_ack_o      (wb_ack_o),
      .wb_dat_o      (wb_dat_o),
      .header_o      (header),
      .difficulty_o  (difficulty),
      .start_nonce_o (start_nonce),
      .run_o         (run),
      .test_o        (test),
      .halt_o        (halt),
      .padf_o        (padf),
      .padl_o        (padl)
   );

   nonce_search #(
      .STAGES (STAGES)
   ) u_search (
      .clk           (clk),
      .reset         (reset),
      .run_i         (run),
      .test_i        (test),
      .halt_i        (halt),
      .start_nonce_i (start_nonce),
      .difficulty_i  (difficulty),
      .hash_i        (hash),
      .nonce_o       (nonce),
      .pass_zero_o   (pass_zero),
      .cycle_o       (cycle),
      .solution_o    (solution),
      .status_o      (status)
   );

   keccak_pipeline #(
      .STAGES (STAGES)
   ) u_pipe (
      .clk         (clk),
      .header_i    (header),
      .nonce_i     (nonce),
      .padf_i      (padf),
      .padl_i      (padl),
      .pass_zero_i (pass_zero),
      .cycle_i     (cycle),
      .hash_o      (hash)
   );

endmodule

// ==== testbench/miner_asserts.sv ====
// Bus and search assertions for the miner register file
// Checks the ack pulse and the found status hold
`timescale 1ns/1ns

module miner_asserts (
   input logic clk,
   input logic reset,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i,
   input logic found_i,
   input logic run_i,
   input logic halt_i
);

   // Number of assertion failures so far
   int assert_failures = 0;

   // Ack is a single-cycle pulse
   ack_pulse: assert property (@(posedge clk) disable iff (reset) ack_i |=> !ack_i)
      else begin
         $error("bus ack stayed high for two cycles");
         assert_failures++;
      end

   ack_request: assert property (@(posedge clk) disable iff (reset)
      $rose(ack_i) |-> $past(cyc_i && stb_i))
      else begin
         $error("bus ack rose without a cycle and strobe");
         assert_failures++;
      end

   // Found only drops once run is cleared
   found_hold: assert property (@(posedge clk) disable iff (reset)
      (found_i && run_i) |=> (found_i || !run_i || halt_i))
      else begin
         $error("found status fell while run was still set");
         assert_failures++;
      end

endmodule

bind miner_regs miner_asserts u_asserts (
   .clk     (clk),
   .reset   (reset),
   .cyc_i   (wb_cyc_i),
   .stb_i   (wb_stb_i),
   .ack_i   (wb_ack_o),
   .found_i (status_i[miner_pkg::ST_FOUND]),
   .run_i   (run_o),
   .halt_i  (halt_o)
);

// ==== testbench/keccak_model.svh ====
// Behavioral SHA3 model of the miner block format
// One 136-byte rate block of 32 header bytes, 8 nonce bytes, padf,
// zero fill and padl in the last byte, hashed by Keccak-f[1600]
`ifndef KECCAK_MODEL_SVH
`define KECCAK_MODEL_SVH

function automatic logic [63:0] lane_rotl(input logic [63:0] v, input int n);
   return (v << n) | (v >> ((64 - n) % 64));
endfunction

// Full 24-round permutation, lane index is x + 5*y
function automatic logic [1599:0] keccak_permute(input logic [1599:0] st);
   logic [24:0][63:0] a;
   logic [24:0][63:0] b;
   logic [4:0][63:0]  c;
   logic [24:0][5:0]  rot;
   logic [63:0]       d;
   logic [63:0]       rc;
   logic [7:0]        lfsr;
   int                x;
   int                y;
   int                t;
   a = st;
   // Rho offsets from the (x,y) walk starting at (1,0)
   rot = '0;
   x = 1;
   y = 0;
   for (int s = 0; s < 24; s++) begin
      rot[x + 5*y] = 6'(((s + 1) * (s + 2) / 2) % 64);
      t = y;
      y = (2*x + 3*y) % 5;
      x = t;
   end
   lfsr = 8'h01;
   for (int r = 0; r < 24; r++) begin
      for (int xi = 0; xi < 5; xi++) begin
         c[xi] = a[xi] ^ a[xi+5] ^ a[xi+10] ^ a[xi+15] ^ a[xi+20];
      end
      for (int xi = 0; xi < 5; xi++) begin
         d = c[(xi+4)%5] ^ lane_rotl(c[(xi+1)%5], 1);
         for (int yi = 0; yi < 5; yi++) begin
            a[xi + 5*yi] = a[xi + 5*yi] ^ d;
         end
      end
      for (int yi = 0; yi < 5; yi++) begin
         for (int xi = 0; xi < 5; xi++) begin
            b[yi + 5*((2*xi + 3*yi) % 5)] = lane_rotl(a[xi + 5*yi], int'(rot[xi + 5*yi]));
         end
      end
      for (int yi = 0; yi < 5; yi++) begin
         for (int xi = 0; xi < 5; xi++) begin
            a[xi + 5*yi] = b[xi + 5*yi] ^ (~b[(xi+1)%5 + 5*yi] & b[(xi+2)%5 + 5*yi]);
         end
      end
      // Iota constant from the standard LFSR
      rc = '0;
      for (int j = 0; j < 7; j++) begin
         rc[(1 << j) - 1] = lfsr[0];
         lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
      end
      a[0] = a[0] ^ rc;
   end
   return a;
endfunction

function automatic logic [255:0] sha3_block_hash(input logic [255:0] hdr,
                                                 input logic [63:0]  nonce,
                                                 input logic [7:0]   padf,
                                                 input logic [7:0]   padl);
   logic [135:0][7:0] msg;
   logic [24:0][63:0] st;
   logic [255:0]      digest;
   msg = '0;
   for (int i = 0; i < 32; i++) begin
      msg[i] = hdr[255 - 8*i -: 8];
   end
   for (int i = 0; i < 8; i++) begin
      msg[32 + i] = nonce[63 - 8*i -: 8];
   end
   msg[40] = padf;
   msg[135] = padl;
   // Lanes take message bytes little-endian
   st = '0;
   for (int k = 0; k < 17; k++) begin
      for (int j = 0; j < 8; j++) begin
         st[k][8*j +: 8] = msg[8*k + j];
      end
   end
   st = keccak_permute(st);
   for (int i = 0; i < 32; i++) begin
      digest[255 - 8*i -: 8] = st[i/8][8*(i%8) +: 8];
   end
   return digest;
endfunction

`endif

// ==== testbench/miner_tb.sv ====
// Testbench for the SHA3 miner
// Random jobs over the register bus, checked against a behavioral
// SHA3 model, plus test mode, halt and run clear
`timescale 1ns/1ns

module miner_tb;

   // Jobs times a per-job budget of twelve hash periods plus bus traffic
   localparam int TIMEOUT_CYCLES = 20 * (12 * 24 + 200);

   localparam logic [2:0] RUN_FLAG  = 3'b001;
   localparam logic [2:0] TEST_FLAG = 3'b010;
   localparam logic [2:0] HALT_FLAG = 3'b100;

   logic        clk;
   logic        reset;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [3:0]  wb_sel;
   logic [6:0]  wb_adr;
   logic [31:0] wb_dat_w;
   logic        wb_ack;
   logic [31:0] wb_dat_r;
   int          cycle_count;
   int          check_count;
   int          error_count;

   `include "keccak_model.svh"

   miner_top #(
      .STAGES (4)
   ) u_dut (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_sel_i (wb_sel),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_w),
      .wb_ack_o (wb_ack),
      .wb_dat_o (wb_dat_r)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Checks: %0d, errors: %0d", check_count, error_count);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   task automatic compare_value(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
      check_count++;
      assert (got === exp) else begin
         error_count++;
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // Hold the request until ack, then drop the strobe
   task automatic write_word(input int idx, input logic [31:0] data, input logic [3:0] sel);
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_sel   = sel;
      wb_adr   = 7'(idx * 4);
      wb_dat_w = data;
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic read_word(input int idx, output logic [31:0] data);
      @(negedge clk);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = 7'(idx * 4);
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      data   = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic read_solution(output logic [63:0] soln);
      logic [31:0] lo;
      logic [31:0] hi;
      read_word(miner_pkg::REG_SOLN_LO, lo);
      read_word(miner_pkg::REG_SOLN_HI, hi);
      soln = {hi, lo};
   endtask

   function automatic logic [255:0] random_hash();
      logic [255:0] v;
      for (int i = 0; i < 8; i++) begin
         v[32*i +: 32] = $urandom;
      end
      return v;
   endfunction

   // Lowest word index carries the most significant bits
   task automatic load_job(input logic [255:0] hdr, input logic [255:0] diff,
                           input logic [63:0] start);
      for (int k = 0; k < 8; k++) begin
         write_word(miner_pkg::REG_HDR + k, hdr[255 - 32*k -: 32], 4'hf);
         write_word(miner_pkg::REG_DIFF + k, diff[255 - 32*k -: 32], 4'hf);
      end
      write_word(miner_pkg::REG_START, start[63:32], 4'hf);
      write_word(miner_pkg::REG_START + 1, start[31:0], 4'hf);
   endtask

   task automatic set_control(input logic [7:0] padf, input logic [7:0] padl,
                              input logic [2:0] flags);
      logic [31:0] ctl;
      ctl = (32'(padf) << 24) | (32'(padl) << 16) | 32'(flags);
      write_word(miner_pkg::REG_CTL, ctl, 4'hf);
   endtask

   task automatic wait_found();
      logic [31:0] st;
      st = '0;
      while (!st[0]) read_word(miner_pkg::REG_STATUS, st);
   endtask

   // Clearing run resets the search and reloads the start nonce
   task automatic clear_run(input logic [7:0] padf, input logic [7:0] padl,
                            input logic [63:0] start);
      logic [31:0] st;
      logic [63:0] soln;
      set_control(padf, padl, 3'b000);
      read_word(miner_pkg::REG_STATUS, st);
      compare_value("running and found after run clear", st[1:0], 2'b00);
      read_solution(soln);
      compare_value("solution after run clear", soln, start);
   endtask

   task automatic register_access();
      logic [31:0] rd;
      logic [31:0] first;
      logic [31:0] second;
      logic [31:0] expected;
      logic [3:0]  sel;
      int          idx;
      read_word(miner_pkg::REG_ID, rd);
      compare_value("ID word", rd, "SHA3");
      write_word(miner_pkg::REG_ID, $urandom, 4'hf);
      read_word(miner_pkg::REG_ID, rd);
      compare_value("ID word after write", rd, "SHA3");
      for (int i = 0; i < 8; i++) begin
         idx    = miner_pkg::REG_HDR + $urandom % (miner_pkg::REG_CTL - miner_pkg::REG_HDR);
         first  = $urandom;
         second = $urandom;
         sel    = 4'($urandom);
         write_word(idx, first, 4'hf);
         write_word(idx, second, sel);
         for (int b = 0; b < 4; b++) begin
            expected[8*b +: 8] = sel[b] ? second[8*b +: 8] : first[8*b +: 8];
         end
         read_word(idx, rd);
         compare_value("job word byte-select readback", rd, expected);
      end
   endtask

   task automatic normal_search();
      logic [255:0] hdr;
      logic [255:0] best;
      logic [255:0] h;
      logic [63:0]  start;
      logic [63:0]  expect_soln;
      logic [63:0]  soln;
      logic [31:0]  st;
      logic [7:0]   padf;
      logic [7:0]   padl;
      int           n;
      hdr   = random_hash();
      start = {$urandom, $urandom};
      padf  = 8'($urandom);
      padl  = 8'($urandom);
      n     = 1 + $urandom % 12;
      best  = '1;
      expect_soln = start;
      // First nonce reaching the smallest hash of the window
      for (int i = 0; i < n; i++) begin
         h = sha3_block_hash(hdr, start + 64'(i), padf, padl);
         if (h < best) begin
            best = h;
            expect_soln = start + 64'(i);
         end
      end
      load_job(hdr, best, start);
      set_control(padf, padl, RUN_FLAG);
      wait_found();
      read_solution(soln);
      compare_value("normal search solution", soln, expect_soln);
      read_word(miner_pkg::REG_STATUS, st);
      compare_value("normal search status", st, 32'h3);
      clear_run(padf, padl, start);
   endtask

   task automatic exact_search();
      logic [255:0] hdr;
      logic [255:0] diff;
      logic [63:0]  start;
      logic [63:0]  soln;
      logic [31:0]  st;
      logic [7:0]   padf;
      logic [7:0]   padl;
      int           k;
      hdr   = random_hash();
      start = {$urandom, $urandom};
      padf  = 8'($urandom);
      padl  = 8'($urandom);
      k     = $urandom % 12;
      diff  = sha3_block_hash(hdr, start + 64'(k), padf, padl);
      load_job(hdr, diff, start);
      set_control(padf, padl, RUN_FLAG | TEST_FLAG);
      wait_found();
      read_solution(soln);
      compare_value("test mode solution", soln, start + 64'(k));
      read_word(miner_pkg::REG_STATUS, st);
      compare_value("test mode status", st, 32'h7);
      clear_run(padf, padl, start);
   endtask

   task automatic halted_search();
      logic [63:0] start;
      logic [63:0] first;
      logic [63:0] second;
      logic [31:0] st;
      logic [7:0]  padf;
      logic [7:0]  padl;
      start = {$urandom, $urandom};
      padf  = 8'h06;
      padl  = 8'h80;
      load_job(random_hash(), '0, start);
      set_control(padf, padl, RUN_FLAG | HALT_FLAG);
      repeat (100) @(negedge clk);
      read_word(miner_pkg::REG_STATUS, st);
      compare_value("halt running and found", st[1:0], 2'b10);
      read_solution(first);
      repeat (20) @(negedge clk);
      read_solution(second);
      compare_value("halt solution held", second, first);
      clear_run(padf, padl, start);
   endtask

   initial begin
      int assert_errors;
      void'($urandom(62));
      clk         = 1'b0;
      reset       = 1'b1;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_sel      = 4'h0;
      wb_adr      = '0;
      wb_dat_w    = '0;
      cycle_count = 0;
      check_count = 0;
      error_count = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      register_access();
      for (int j = 0; j < 6; j++) begin
         normal_search();
      end
      for (int j = 0; j < 4; j++) begin
         exact_search();
      end
      halted_search();
      assert_errors = u_dut.u_regs.u_asserts.assert_failures;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               check_count, error_count, assert_errors);
      if (error_count == 0 && assert_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== miner_top.f ====
+incdir+testbench
logic/miner_pkg.sv
logic/keccak_round.sv
logic/keccak_pipeline.sv
logic/nonce_search.sv
logic/miner_regs.sv
logic/miner_top.sv
testbench/miner_asserts.sv
testbench/miner_tb.sv
